// ==== compile.f ====
design/pov_pkg.sv
design/cmd_bus_if.sv
design/column_if.sv
design/spi_receiver.sv
design/cmd_decoder.sv
design/rev_emulator.sv
design/led_driver_ctrl.sv
design/pov_display_top.sv
test/tb_pov_display.sv

// ==== design/cmd_bus_if.sv ====
interface cmd_bus_if;

    // One-cycle strobe per finished transaction
    logic                           cmd_valid;
    // Raw command bytes, byte 0 first received
    pov_pkg::cmd_buf_t              cmd_bytes;
    // Number of bytes stored in cmd_bytes
    logic [pov_pkg::CMD_LEN_W-1:0]  cmd_len;
    // More bytes arrived than the buffer holds
    logic                           cmd_overflow;

    // SPI side
    modport rx (output cmd_valid, output cmd_bytes, output cmd_len, output cmd_overflow);

    // Decoder side
    modport dec (input cmd_valid, input cmd_bytes, input cmd_len, input cmd_overflow);

endinterface

// ==== design/cmd_decoder.sv ====
module cmd_decoder #(
    parameter int NUM_COLUMNS   = 8,
    parameter int NUM_LANES     = 4,
    parameter int BITS_PER_LANE = 16
) (
    input  logic   clk,
    input  logic   rst_n,
    cmd_bus_if.dec cmd,
    column_if.mem  col
);

    localparam int COL_BITS  = NUM_LANES * BITS_PER_LANE;
    localparam int COL_BYTES = COL_BITS / 8;
    localparam int IDX_W     = (NUM_COLUMNS > 1) ? $clog2(NUM_COLUMNS) : 1;
    localparam int LEN_W     = pov_pkg::CMD_LEN_W;

    // Column store and display enable
    logic [COL_BITS-1:0] col_mem [NUM_COLUMNS];
    logic                enable_q;

    // Decoded fields
    logic [7:0]          opcode;
    logic [7:0]          index;
    logic [COL_BITS-1:0] payload;
    logic                len_col_ok;
    logic                len_cfg_ok;
    logic                col_write;
    logic                cfg_write;

    always_comb begin
        opcode = cmd.cmd_bytes[0];
        index  = cmd.cmd_bytes[1];
        // First payload byte lands in the top of the column
        for (int b = 0; b < COL_BYTES; b++) begin
            payload[COL_BITS-1-8*b -: 8] = cmd.cmd_bytes[pov_pkg::COLUMN_HDR_LEN + b];
        end
    end

    // Lengths must match exactly
    assign len_col_ok = (cmd.cmd_len == LEN_W'(pov_pkg::COLUMN_HDR_LEN + COL_BYTES));
    assign len_cfg_ok = (cmd.cmd_len == LEN_W'(pov_pkg::CONFIG_CMD_LEN));

    // Overflowed transactions are dropped whatever the opcode
    assign col_write = cmd.cmd_valid && !cmd.cmd_overflow
                     && (opcode == pov_pkg::OP_WRITE_COLUMN)
                     && len_col_ok
                     && (int'(index) < NUM_COLUMNS);

    assign cfg_write = cmd.cmd_valid && !cmd.cmd_overflow
                     && (opcode == pov_pkg::OP_WRITE_CONFIG)
                     && len_cfg_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Display starts dark and blank
            enable_q <= 1'b0;
            for (int c = 0; c < NUM_COLUMNS; c++) begin
                col_mem[c] <= '0;
            end
        end else begin
            if (col_write) begin
                col_mem[index[IDX_W-1:0]] <= payload;
            end
            if (cfg_write) begin
                // Config byte sits right after the opcode
                enable_q <= cmd.cmd_bytes[1][0];
            end
        end
    end

    // Fetch is combinational, driver samples in the same cycle
    assign col.col_data       = col_mem[col.col_index];
    assign col.display_enable = enable_q;

endmodule

// ==== design/column_if.sv ====
interface column_if #(
    parameter int NUM_COLUMNS   = 8,
    parameter int NUM_LANES     = 4,
    parameter int BITS_PER_LANE = 16
);

    localparam int COL_BITS = NUM_LANES * BITS_PER_LANE;
    localparam int IDX_W    = (NUM_COLUMNS > 1) ? $clog2(NUM_COLUMNS) : 1;

    // Column requested by the driver
    logic [IDX_W-1:0]    col_index;
    // Column word, valid in the same cycle as col_index
    logic [COL_BITS-1:0] col_data;
    logic                display_enable;
    // Start of a revolution, realigns the column count
    logic                revolution_pulse;

    modport drv (output col_index, input col_data, input display_enable, input revolution_pulse);

    modport mem (input col_index, output col_data, output display_enable);

endinterface

// ==== design/led_driver_ctrl.sv ====
module led_driver_ctrl #(
    parameter int NUM_COLUMNS   = 8,
    parameter int NUM_LANES     = 4,
    parameter int BITS_PER_LANE = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   column_tick,
    column_if.drv                  col,
    output logic                   drv_sclk,
    output logic                   drv_gclk,
    output logic                   drv_lat,
    output logic [NUM_LANES-1:0]   drv_sin,
    output logic [NUM_COLUMNS-1:0] col_sel
);

    localparam int COL_BITS = NUM_LANES * BITS_PER_LANE;
    localparam int IDX_W    = (NUM_COLUMNS > 1) ? $clog2(NUM_COLUMNS) : 1;
    localparam int BIT_W    = (BITS_PER_LANE > 1) ? $clog2(BITS_PER_LANE) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_LATCH
    } state_t;

    state_t              state;
    logic [IDX_W-1:0]    col_cnt;
    logic [IDX_W-1:0]    next_idx;
    logic [BIT_W-1:0]    bit_cnt;
    logic [COL_BITS-1:0] shreg;
    // Enable as seen at fetch time
    logic                show_q;

    // Column for the coming tick, revolution start forces column 0
    always_comb begin
        if (col.revolution_pulse) begin
            next_idx = '0;
        end else if (col_cnt == IDX_W'(NUM_COLUMNS - 1)) begin
            next_idx = '0;
        end else begin
            next_idx = col_cnt + IDX_W'(1);
        end
    end

    assign col.col_index = next_idx;

    // Lane k takes its own slice, lane 0 the lowest
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            drv_sin[k] = shreg[k*BITS_PER_LANE + BITS_PER_LANE - 1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            // First tick after reset shows column 0
            col_cnt  <= IDX_W'(NUM_COLUMNS - 1);
            bit_cnt  <= '0;
            shreg    <= '0;
            show_q   <= 1'b0;
            drv_sclk <= 1'b0;
            drv_lat  <= 1'b0;
            drv_gclk <= 1'b0;
            col_sel  <= '0;
        end else begin
            // Grayscale clock runs at half the system clock
            drv_gclk <= col.display_enable ? ~drv_gclk : 1'b0;
            drv_lat  <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (column_tick) begin
                        col_cnt  <= next_idx;
                        show_q   <= col.display_enable;
                        // Blank frame when disabled, shifting still runs
                        shreg    <= col.display_enable ? col.col_data : '0;
                        bit_cnt  <= '0;
                        drv_sclk <= 1'b0;
                        state    <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    if (!drv_sclk) begin
                        // Data has been stable for the low phase
                        drv_sclk <= 1'b1;
                    end else begin
                        drv_sclk <= 1'b0;
                        bit_cnt  <= bit_cnt + BIT_W'(1);
                        // Advance every lane by one bit, MSB first
                        for (int k = 0; k < NUM_LANES; k++) begin
                            shreg[k*BITS_PER_LANE +: BITS_PER_LANE] <=
                                {shreg[k*BITS_PER_LANE +: BITS_PER_LANE-1], 1'b0};
                        end
                        if (bit_cnt == BIT_W'(BITS_PER_LANE - 1)) begin
                            state <= ST_LATCH;
                        end
                    end
                end
                ST_LATCH: begin
                    // Latch and column select change together
                    drv_lat <= 1'b1;
                    col_sel <= show_q ? (NUM_COLUMNS'(1) << col_cnt) : '0;
                    state   <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/pov_display_top.sv ====
module pov_display_top #(
    parameter int NUM_LANES     = 4,
    parameter int BITS_PER_LANE = 16,
    parameter int NUM_COLUMNS   = 8,
    parameter int COLUMN_PERIOD = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    // Host SPI
    input  logic                   spi_sclk,
    input  logic                   spi_cs_n,
    input  logic                   spi_mosi,
    output logic                   spi_miso,
    // LED drivers
    output logic                   drv_sclk,
    output logic                   drv_gclk,
    output logic                   drv_lat,
    output logic [NUM_LANES-1:0]   drv_sin,
    output logic [NUM_COLUMNS-1:0] col_sel
);

    logic        column_tick;
    logic        revolution_pulse;
    logic [15:0] rev_count;

    cmd_bus_if cmd_bus ();

    column_if #(
        .NUM_COLUMNS  (NUM_COLUMNS),
        .NUM_LANES    (NUM_LANES),
        .BITS_PER_LANE(BITS_PER_LANE)
    ) col_bus ();

    // Driver realigns on each revolution
    assign col_bus.revolution_pulse = revolution_pulse;

    spi_receiver spi_receiver (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .rev_count(rev_count),
        .cmd      (cmd_bus.rx)
    );

    cmd_decoder #(
        .NUM_COLUMNS  (NUM_COLUMNS),
        .NUM_LANES    (NUM_LANES),
        .BITS_PER_LANE(BITS_PER_LANE)
    ) cmd_decoder (
        .clk  (clk),
        .rst_n(rst_n),
        .cmd  (cmd_bus.dec),
        .col  (col_bus.mem)
    );

    rev_emulator #(
        .COLUMN_PERIOD(COLUMN_PERIOD),
        .NUM_COLUMNS  (NUM_COLUMNS)
    ) rev_emulator (
        .clk             (clk),
        .rst_n           (rst_n),
        .column_tick     (column_tick),
        .revolution_pulse(revolution_pulse),
        .rev_count       (rev_count)
    );

    led_driver_ctrl #(
        .NUM_COLUMNS  (NUM_COLUMNS),
        .NUM_LANES    (NUM_LANES),
        .BITS_PER_LANE(BITS_PER_LANE)
    ) led_driver_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .column_tick(column_tick),
        .col        (col_bus.drv),
        .drv_sclk   (drv_sclk),
        .drv_gclk   (drv_gclk),
        .drv_lat    (drv_lat),
        .drv_sin    (drv_sin),
        .col_sel    (col_sel)
    );

endmodule

// ==== design/pov_pkg.sv ====
package pov_pkg;

    // Opcodes, first byte of every command
    // Column write: opcode, index, then the column bytes MSB first
    localparam logic [7:0] OP_WRITE_COLUMN = 8'h01;
    // Config write: opcode, config byte (bit 0 is display enable)
    localparam logic [7:0] OP_WRITE_CONFIG = 8'h02;

    // First byte on MISO in every transaction
    localparam logic [7:0] STATUS_ID = 8'hA5;

    // Command buffer depth in bytes
    // Opcode, index and up to 8 payload bytes
    localparam int MAX_CMD_BYTES = 10;

    // Width of the byte counter, must hold MAX_CMD_BYTES itself
    localparam int CMD_LEN_W = $clog2(MAX_CMD_BYTES + 1);

    // Exact length of a config write
    localparam int CONFIG_CMD_LEN = 2;

    // Bytes ahead of the payload in a column write
    localparam int COLUMN_HDR_LEN = 2;

    // Received command bytes
    // Index 0 holds the first byte on the wire
    typedef logic [MAX_CMD_BYTES-1:0][7:0] cmd_buf_t;

endpackage

// ==== design/rev_emulator.sv ====
module rev_emulator #(
    parameter int COLUMN_PERIOD = 64,
    parameter int NUM_COLUMNS   = 8
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        column_tick,
    output logic        revolution_pulse,
    output logic [15:0] rev_count
);

    localparam int PERIOD_W = (COLUMN_PERIOD > 1) ? $clog2(COLUMN_PERIOD) : 1;
    localparam int COL_W    = (NUM_COLUMNS > 1) ? $clog2(NUM_COLUMNS) : 1;

    logic [PERIOD_W-1:0] period_cnt;
    logic [COL_W-1:0]    col_cnt;
    logic                period_end;
    logic                last_col;

    assign period_end = (period_cnt == PERIOD_W'(COLUMN_PERIOD - 1));
    assign last_col   = (col_cnt == COL_W'(NUM_COLUMNS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period_cnt       <= '0;
            col_cnt          <= '0;
            column_tick      <= 1'b0;
            revolution_pulse <= 1'b0;
            rev_count        <= '0;
        end else begin
            // Ticks are registered, so the first appears a full period after reset
            column_tick      <= period_end;
            revolution_pulse <= period_end && last_col;

            if (period_end) begin
                period_cnt <= '0;
                // Count ticks within one revolution
                col_cnt    <= last_col ? '0 : col_cnt + COL_W'(1);
            end else begin
                period_cnt <= period_cnt + PERIOD_W'(1);
            end

            // Wraps at 16 bits
            if (revolution_pulse) begin
                rev_count <= rev_count + 16'd1;
            end
        end
    end

endmodule

// ==== design/spi_receiver.sv ====
module spi_receiver (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        spi_sclk,
    input  logic        spi_cs_n,
    input  logic        spi_mosi,
    output logic        spi_miso,
    input  logic [15:0] rev_count,
    cmd_bus_if.rx       cmd
);

    localparam int LEN_W = pov_pkg::CMD_LEN_W;

    // Pin synchronizers, bit order {sclk, cs_n, mosi}
    logic [2:0] pin_meta;
    logic [2:0] pin_sync;
    logic       sclk_s;
    logic       cs_s;
    logic       mosi_s;
    logic       sclk_prev;
    logic       cs_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_rise;
    logic       cs_fall;

    // Receive path
    logic [2:0]        bit_cnt;
    logic [6:0]        rx_shift;
    logic [LEN_W-1:0]  byte_cnt;
    logic              overflow;
    logic              byte_done;
    logic              buf_full;
    logic              valid_q;
    pov_pkg::cmd_buf_t cmd_buf;

    // Status reply, ID byte then revolution count
    logic [23:0] reply;

    assign sclk_s = pin_sync[2];
    assign cs_s   = pin_sync[1];
    assign mosi_s = pin_sync[0];

    assign sclk_rise = sclk_s & ~sclk_prev;
    assign sclk_fall = ~sclk_s & sclk_prev;
    assign cs_rise   = cs_s & ~cs_prev;
    assign cs_fall   = ~cs_s & cs_prev;

    // Eighth bit of a byte arriving while selected
    assign byte_done = ~cs_s & sclk_rise & (bit_cnt == 3'd7);
    assign buf_full  = (byte_cnt >= LEN_W'(pov_pkg::MAX_CMD_BYTES));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Idle bus: sclk low, chip select high
            pin_meta  <= 3'b010;
            pin_sync  <= 3'b010;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
            bit_cnt   <= '0;
            byte_cnt  <= '0;
            overflow  <= 1'b0;
            valid_q   <= 1'b0;
            reply     <= '0;
        end else begin
            pin_meta  <= {spi_sclk, spi_cs_n, spi_mosi};
            pin_sync  <= pin_meta;
            sclk_prev <= sclk_s;
            cs_prev   <= cs_s;

            // Empty transactions produce no command
            valid_q <= cs_rise && (byte_cnt != '0);

            if (cs_fall) begin
                bit_cnt  <= '0;
                byte_cnt <= '0;
                overflow <= 1'b0;
                // Count sampled once per transaction
                reply    <= {pov_pkg::STATUS_ID, rev_count};
            end else if (cs_rise) begin
                reply <= '0;
            end else if (!cs_s) begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
                if (byte_done) begin
                    if (buf_full) begin
                        overflow <= 1'b1;
                    end else begin
                        byte_cnt <= byte_cnt + LEN_W'(1);
                    end
                end
                // Mode 0, next bit goes out on the falling edge
                if (sclk_fall) begin
                    reply <= {reply[22:0], 1'b0};
                end
            end
        end
    end

    // Byte assembly, MSB first
    always_ff @(posedge clk) begin
        if (!cs_s && sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_s};
        end
        if (byte_done && !buf_full) begin
            cmd_buf[byte_cnt] <= {rx_shift, mosi_s};
        end
    end

    assign spi_miso = reply[23];

    assign cmd.cmd_valid    = valid_q;
    assign cmd.cmd_bytes    = cmd_buf;
    assign cmd.cmd_len      = byte_cnt;
    assign cmd.cmd_overflow = overflow;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f compile.f \
        --top-module tb_pov_display -o tb_pov_display; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_pov_display)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1

// ==== test/tb_pov_display.sv ====
module tb_pov_display;

    localparam int NUM_LANES     = 4;
    localparam int BITS_PER_LANE = 16;
    localparam int NUM_COLUMNS   = 8;
    localparam int COLUMN_PERIOD = 64;
    localparam int COL_BITS      = NUM_LANES * BITS_PER_LANE;
    localparam int COL_BYTES     = COL_BITS / 8;
    // One full revolution in clk cycles
    localparam int REV_CYCLES    = NUM_COLUMNS * COLUMN_PERIOD;
    // Longest wait for the latch pulses of one check
    localparam int LATCH_TIMEOUT = 2 * (NUM_COLUMNS + 2) * COLUMN_PERIOD;
    // clk cycles per SPI half-period
    localparam int SPI_HALF      = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   spi_sclk;
    logic                   spi_cs_n;
    logic                   spi_mosi;
    logic                   spi_miso;
    logic                   drv_sclk;
    logic                   drv_gclk;
    logic                   drv_lat;
    logic [NUM_LANES-1:0]   drv_sin;
    logic [NUM_COLUMNS-1:0] col_sel;

    int seed = 90126;
    int errors;
    int tests_run;
    int tests_failed;
    int cyc;

    // Expected column memory as built from the commands sent
    logic [COL_BITS-1:0] exp_mem [NUM_COLUMNS];

    // SPI bytes out and bytes read back
    logic [7:0] tx_q [$];
    logic [7:0] rx_q [$];

    // Driver bus monitor state
    logic [COL_BITS-1:0]    mon_word;
    int                     mon_bits;
    logic                   sclk_q;
    logic                   gclk_q;
    int                     gclk_toggles;
    int                     lat_total;
    logic [COL_BITS-1:0]    word_q [$];
    logic [NUM_COLUMNS-1:0] sel_q [$];
    int                     bits_q [$];

    pov_display_top #(
        .NUM_LANES    (NUM_LANES),
        .BITS_PER_LANE(BITS_PER_LANE),
        .NUM_COLUMNS  (NUM_COLUMNS),
        .COLUMN_PERIOD(COLUMN_PERIOD)
    ) dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .spi_sclk(spi_sclk),
        .spi_cs_n(spi_cs_n),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso),
        .drv_sclk(drv_sclk),
        .drv_gclk(drv_gclk),
        .drv_lat (drv_lat),
        .drv_sin (drv_sin),
        .col_sel (col_sel)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Sampled on the falling clk edge where DUT outputs are stable
    always @(negedge clk) begin
        if (!rst_n) begin
            mon_word  = '0;
            mon_bits  = 0;
            sclk_q    = 1'b0;
            gclk_q    = 1'b0;
            lat_total = 0;
        end else begin
            // Drivers take each lane bit on the rising edge of drv_sclk
            if (drv_sclk && !sclk_q) begin
                for (int k = 0; k < NUM_LANES; k++) begin
                    mon_word[k*BITS_PER_LANE +: BITS_PER_LANE] =
                        {mon_word[k*BITS_PER_LANE +: BITS_PER_LANE-1], drv_sin[k]};
                end
                mon_bits++;
            end
            // Latch freezes the word and col_sel switches with it
            if (drv_lat) begin
                word_q.push_back(mon_word);
                sel_q.push_back(col_sel);
                bits_q.push_back(mon_bits);
                mon_bits = 0;
                lat_total++;
            end
            if (drv_gclk !== gclk_q) begin
                gclk_toggles++;
            end
            sclk_q = drv_sclk;
            gclk_q = drv_gclk;
        end
    end

    function automatic logic [COL_BITS-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("Test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL (%0d errors)", name, errors - errs_at_start);
        end
    endtask

    task automatic spi_half_period();
        repeat (SPI_HALF) @(posedge clk);
        #1;
    endtask

    // Mode 0 master sets MOSI with sclk low and takes MISO just before the rise
    task automatic spi_xfer();
        logic [7:0] rx_byte;
        rx_byte = '0;
        rx_q.delete();
        spi_cs_n = 1'b0;
        spi_half_period();
        foreach (tx_q[i]) begin
            for (int b = 7; b >= 0; b--) begin
                spi_mosi = tx_q[i][b];
                spi_half_period();
                rx_byte  = {rx_byte[6:0], spi_miso};
                spi_sclk = 1'b1;
                spi_half_period();
                spi_sclk = 1'b0;
            end
            rx_q.push_back(rx_byte);
        end
        spi_half_period();
        spi_cs_n = 1'b1;
        spi_mosi = 1'b0;
        // Leaves room for the decoder to act on the command
        repeat (2) spi_half_period();
    endtask

    // Opcode and index byte followed by nbytes of data MSB first
    task automatic send_frame(input logic [7:0] op, input logic [7:0] idx,
                              input logic [COL_BITS-1:0] data, input int nbytes);
        tx_q.delete();
        tx_q.push_back(op);
        tx_q.push_back(idx);
        for (int b = 0; b < nbytes; b++) begin
            tx_q.push_back(data[COL_BITS - 1 - 8*(b % COL_BYTES) -: 8]);
        end
        spi_xfer();
    endtask

    task automatic clear_monitor();
        word_q.delete();
        sel_q.delete();
        bits_q.delete();
        gclk_toggles = 0;
    endtask

    task automatic wait_latches(input int n);
        int waited;
        waited = 0;
        while (word_q.size() < n && waited < LATCH_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (word_q.size() < n) begin
            $display("Timeout at time %0t: saw %0d of %0d latch pulses",
                     $time, word_q.size(), n);
            errors++;
        end
    endtask

    // The first latch is dropped because its fetch may predate the last command
    task automatic collect_latches(input int n);
        clear_monitor();
        wait_latches(1);
        clear_monitor();
        wait_latches(n);
    endtask

    task automatic check_shift_length(input int i);
        if (bits_q[i] != BITS_PER_LANE) begin
            report_mismatch($sformatf("latch %0d after %0d drv_sclk pulses", i, bits_q[i]));
        end
    endtask

    task automatic check_blank(input int n);
        collect_latches(n);
        for (int i = 0; i < word_q.size(); i++) begin
            check_shift_length(i);
            if (word_q[i] !== '0 || sel_q[i] !== '0) begin
                report_mismatch($sformatf("blank latch %0d shows word %h, col_sel %b",
                                          i, word_q[i], sel_q[i]));
            end
        end
        if (gclk_toggles != 0 || drv_gclk !== 1'b0) begin
            report_mismatch($sformatf("gclk toggled %0d times while dark", gclk_toggles));
        end
    endtask

    // Word must match the column whose select bit is set and columns come in index order
    task automatic check_display();
        int idx;
        int prev;
        prev = -1;
        collect_latches(NUM_COLUMNS);
        for (int i = 0; i < word_q.size(); i++) begin
            check_shift_length(i);
            if (!$onehot(sel_q[i])) begin
                report_mismatch($sformatf("latch %0d col_sel %b not one-hot", i, sel_q[i]));
            end else begin
                idx = 0;
                for (int c = 0; c < NUM_COLUMNS; c++) begin
                    if (sel_q[i][c]) begin
                        idx = c;
                    end
                end
                if (word_q[i] !== exp_mem[idx]) begin
                    report_mismatch($sformatf("column %0d shifted %h, expected %h",
                                              idx, word_q[i], exp_mem[idx]));
                end
                if (prev >= 0 && idx != (prev + 1) % NUM_COLUMNS) begin
                    report_mismatch($sformatf("column %0d follows column %0d", idx, prev));
                end
                prev = idx;
            end
        end
        if (gclk_toggles < COLUMN_PERIOD) begin
            report_mismatch($sformatf("gclk toggled only %0d times", gclk_toggles));
        end
    endtask

    task automatic test_reset_state();
        int errs;
        errs = errors;
        if (col_sel !== '0 || spi_miso !== 1'b0 || drv_lat !== 1'b0
            || drv_sclk !== 1'b0 || drv_gclk !== 1'b0) begin
            report_mismatch($sformatf("after reset col_sel %b, miso %b, lat %b, sclk %b, gclk %b",
                                      col_sel, spi_miso, drv_lat, drv_sclk, drv_gclk));
        end
        // No latch before the first column tick has been shifted out
        repeat (COLUMN_PERIOD) @(posedge clk);
        #1;
        if (lat_total != 0) begin
            report_mismatch($sformatf("%0d latch pulses before the first column tick",
                                      lat_total));
        end
        check_blank(2);
        report_test("reset_state", errs);
    endtask

    task automatic test_status_reply();
        int          errs;
        int          start;
        logic [15:0] count_a;
        errs  = errors;
        start = cyc;
        // Unknown opcode so only the reply matters here
        send_frame(8'h00, 8'h00, '0, 1);
        if (rx_q[0] !== pov_pkg::STATUS_ID) begin
            report_mismatch($sformatf("first reply byte %h", rx_q[0]));
        end
        count_a = {rx_q[1], rx_q[2]};
        // Second snapshot lands exactly one revolution after the first
        while (cyc < start + REV_CYCLES) begin
            @(posedge clk);
            #1;
        end
        send_frame(8'h00, 8'h00, '0, 1);
        if (rx_q[0] !== pov_pkg::STATUS_ID) begin
            report_mismatch($sformatf("second reply byte %h", rx_q[0]));
        end
        if ({rx_q[1], rx_q[2]} !== count_a + 16'd1) begin
            report_mismatch($sformatf("rev count %h then %h", count_a, {rx_q[1], rx_q[2]}));
        end
        report_test("status_reply", errs);
    endtask

    task automatic test_column_display();
        int errs;
        errs = errors;
        for (int c = 0; c < NUM_COLUMNS; c++) begin
            exp_mem[c] = rand_word();
            send_frame(pov_pkg::OP_WRITE_COLUMN, 8'(c), exp_mem[c], COL_BYTES);
        end
        send_frame(pov_pkg::OP_WRITE_CONFIG, 8'h01, '0, 0);
        check_display();
        report_test("column_display", errs);
    endtask

    task automatic test_disable();
        int errs;
        errs = errors;
        send_frame(pov_pkg::OP_WRITE_CONFIG, 8'h00, '0, 0);
        check_blank(NUM_COLUMNS);
        // Memory survives while dark
        send_frame(pov_pkg::OP_WRITE_CONFIG, 8'h01, '0, 0);
        check_display();
        report_test("disable", errs);
    endtask

    task automatic test_rejected();
        int errs;
        errs = errors;
        send_frame(pov_pkg::OP_WRITE_COLUMN, 8'(NUM_COLUMNS), rand_word(), COL_BYTES);
        send_frame(pov_pkg::OP_WRITE_COLUMN, 8'h00, rand_word(), COL_BYTES - 1);
        send_frame(8'h07, 8'h01, rand_word(), COL_BYTES);
        // 11 bytes is one more than the command buffer holds
        send_frame(pov_pkg::OP_WRITE_COLUMN, 8'h02, rand_word(), COL_BYTES + 1);
        check_display();
        report_test("rejected", errs);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        spi_sclk     = 1'b0;
        spi_cs_n     = 1'b1;
        spi_mosi     = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        gclk_toggles = 0;
        for (int c = 0; c < NUM_COLUMNS; c++) begin
            exp_mem[c] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_status_reply();
        test_column_display();
        test_disable();
        test_rejected();

        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
